// ==== Bender.yml ====
package:
  name: conv_layer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/conv_pkg.sv
      - verilog/coef_if.sv
      - verilog/coef_loader.sv
      - verilog/line_buffer.sv
      - verilog/pixel_window.sv
      - verilog/conv_mac_array.sv
      - verilog/scan_ctrl.sv
      - verilog/conv_layer_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/clk_rst_gen.sv
      - bench/conv_layer_tb.sv

// ==== bench/clk_rst_gen.sv ====
`timescale 1ns/100ps

module clk_rst_gen
#(
	parameter int PERIOD = 8,
	parameter int RST_CYCLES = 3
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// reset released on a rising edge
	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== bench/conv_layer_tb.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_layer_tb;

	localparam int WIDTH = `CONV_WIDTH;
	localparam int OUT_W = `CONV_WIDTH - 2;
	localparam int CH = `CONV_CHANNELS;
	localparam int DW = `CONV_DATA_W;
	localparam int AW = `CONV_ADDR_W;
	localparam int W_WORDS = `CONV_CHANNELS * `CONV_TAPS;
	localparam int PIXELS = `CONV_WIDTH * `CONV_WIDTH;
	localparam int OUTPUTS = OUT_W * OUT_W;

	localparam int GOAL_RESET_DONE = 0;
	localparam int GOAL_LOADED = 1;
	localparam int GOAL_SCAN = 2;
	localparam int GOAL_DONE_1 = 3;
	localparam int GOAL_DONE_2 = 4;

	logic           clk;
	logic           rst;
	logic           weight_store_done;
	logic           bias_store_done;
	logic           pixel_store_done;
	logic [DW-1:0]  input_data;
	logic [DW-1:0]  weight_data;
	logic [DW-1:0]  bias_data;
	logic           save_enable;
	logic [AW-1:0]  output_row;
	logic [AW-1:0]  output_col;
	logic [CH*DW-1:0] output_data;
	logic           layer_done;
	logic           read_pixel_signal;
	logic [AW-1:0]  read_col_addr;
	logic [AW-1:0]  read_row_addr;
	logic           read_weight_signal;
	logic [AW-1:0]  read_weight_addr;
	logic           read_bias_signal;
	logic [AW-1:0]  read_bias_addr;

	logic [DW-1:0] wmem [W_WORDS];
	logic [DW-1:0] bmem [CH];
	logic [DW-1:0] pix [PIXELS];
	logic [31:0]   lfsr;

	// progress counters updated on each rising edge
	logic started;
	logic w_sent;
	logic b_sent;
	logic w_shifted;
	logic b_shifted;
	logic scan_active;
	int   w_reads;
	int   b_reads;
	int   p_reads;
	int   save_cnt;
	int   done_cnt;
	logic [4:0] strobes;

	int test_errors [1:6] = '{default: 0};
	int n_pass = 0;
	int n_fail = 0;

	clk_rst_gen #(
		.PERIOD     (8),
		.RST_CYCLES (3)
	) u_clk_rst (
		.clk (clk),
		.rst (rst)
	);

	conv_layer_top u_dut (
		.clk                (clk),
		.rst                (rst),
		.weight_store_done  (weight_store_done),
		.bias_store_done    (bias_store_done),
		.pixel_store_done   (pixel_store_done),
		.input_data         (input_data),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.save_enable        (save_enable),
		.output_row         (output_row),
		.output_col         (output_col),
		.output_data        (output_data),
		.layer_done         (layer_done),
		.read_pixel_signal  (read_pixel_signal),
		.read_col_addr      (read_col_addr),
		.read_row_addr      (read_row_addr),
		.read_weight_signal (read_weight_signal),
		.read_weight_addr   (read_weight_addr),
		.read_bias_signal   (read_bias_signal),
		.read_bias_addr     (read_bias_addr)
	);

	assign strobes = {read_weight_signal, read_bias_signal, read_pixel_signal,
		save_enable, layer_done};

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic random_word(output logic [DW-1:0] w);
		for (int b = 0; b < DW; b++)
		begin
			lfsr = lfsr_next(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	task automatic fill_coefficients();
		logic [DW-1:0] w;
		for (int a = 0; a < W_WORDS; a++)
		begin
			random_word(w);
			wmem[a] = w;
		end
		for (int a = 0; a < CH; a++)
		begin
			random_word(w);
			bmem[a] = w;
		end
	endtask

	task automatic fill_image();
		logic [DW-1:0] w;
		for (int a = 0; a < PIXELS; a++)
		begin
			random_word(w);
			pix[a] = w;
		end
	endtask

	// weight address a is tap * channels + channel
	// all arithmetic wraps mod 2^16
	function automatic logic [DW-1:0] expected_channel(input int row, input int col, input int ch);
		logic [DW-1:0] acc;
		acc = bmem[ch];
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				acc = acc + wmem[(3 * i + j) * CH + ch] * pix[(row + i) * WIDTH + col + j];
			end
		end
		return acc;
	endfunction

	function automatic logic [63:0] pack_pos(input int row, input int col);
		return {32'd0, AW'(row), AW'(col)};
	endfunction

	task automatic report_mismatch(input int test_id, input string sig,
		input logic [63:0] exp, input logic [63:0] act);
		test_errors[test_id]++;
		$display("[ERROR] t=%0t %s: expected 0x%0h, got 0x%0h", $time, sig, exp, act);
	endtask

	task automatic report_fault(input int test_id, input string what);
		test_errors[test_id]++;
		$display("test %0d failure at t=%0t: %s", test_id, $time, what);
	endtask

	task automatic finish_test(input int test_id, input string name);
		if (test_errors[test_id] == 0)
		begin
			n_pass++;
			$display("test %0d %s: ok", test_id, name);
		end
		else
		begin
			n_fail++;
			$display("test %0d %s: failed with %0d errors", test_id, name, test_errors[test_id]);
		end
	endtask

	function automatic bit reached(input int goal);
		case (goal)
			GOAL_RESET_DONE: return !rst;
			GOAL_LOADED:     return w_shifted && b_shifted;
			GOAL_SCAN:       return scan_active;
			GOAL_DONE_1:     return done_cnt >= 1;
			GOAL_DONE_2:     return done_cnt >= 2;
			default:         return 1'b0;
		endcase
	endfunction

	task automatic wait_until(input int goal, input int limit, input string what);
		int n;
		n = 0;
		while (!reached(goal) && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (!reached(goal))
		begin
			$display("timed out after %0d cycles waiting for %s", limit, what);
			$display("Some tests failed");
			$finish;
		end
	endtask

	// memories answer one cycle after the strobe
	always @(posedge clk)
	begin
		if (read_weight_signal)
			weight_data <= wmem[read_weight_addr];
		if (read_bias_signal)
			bias_data <= bmem[read_bias_addr];
		if (read_pixel_signal)
			input_data <= pix[read_row_addr * WIDTH + read_col_addr];
	end

	always @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_reads <= 0;
			b_reads <= 0;
			p_reads <= 0;
			save_cnt <= 0;
			done_cnt <= 0;
			w_sent <= 1'b0;
			b_sent <= 1'b0;
			w_shifted <= 1'b0;
			b_shifted <= 1'b0;
			scan_active <= 1'b0;
		end
		else
		begin
			if (read_weight_signal)
				w_reads <= w_reads + 1;
			if (read_bias_signal)
				b_reads <= b_reads + 1;
			if (read_weight_signal && w_reads == W_WORDS - 1)
				w_sent <= 1'b1;
			if (read_bias_signal && b_reads == CH - 1)
				b_sent <= 1'b1;
			// last word is in the bank one edge after it was returned
			w_shifted <= w_sent;
			b_shifted <= b_sent;
			if (layer_done)
			begin
				done_cnt <= done_cnt + 1;
				p_reads <= 0;
				save_cnt <= 0;
				scan_active <= 1'b0;
			end
			else
			begin
				if (read_pixel_signal)
				begin
					p_reads <= p_reads + 1;
					scan_active <= 1'b1;
				end
				if (save_enable)
					save_cnt <= save_cnt + 1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) !started |-> strobes == 5'b0)
	else
		report_mismatch(1, "{rd_w,rd_b,rd_p,save,done}", 0, $sampled(strobes));

	assert property (@(posedge clk) disable iff (rst)
		read_weight_signal |-> read_weight_addr == w_reads)
	else
		report_mismatch(2, "read_weight_addr", $sampled(w_reads), $sampled(read_weight_addr));

	assert property (@(posedge clk) disable iff (rst) read_weight_signal |-> w_reads < W_WORDS)
	else
		report_fault(2, "weight read issued after the last weight address");

	assert property (@(posedge clk) disable iff (rst)
		(w_reads > 0 && w_reads < W_WORDS) |-> read_weight_signal)
	else
		report_fault(2, "weight reads were not on consecutive cycles");

	assert property (@(posedge clk) disable iff (rst)
		read_bias_signal |-> read_bias_addr == b_reads)
	else
		report_mismatch(2, "read_bias_addr", $sampled(b_reads), $sampled(read_bias_addr));

	assert property (@(posedge clk) disable iff (rst) read_bias_signal |-> b_reads < CH)
	else
		report_fault(2, "bias read issued after the last bias address");

	assert property (@(posedge clk) disable iff (rst)
		(b_reads > 0 && b_reads < CH) |-> read_bias_signal)
	else
		report_fault(2, "bias reads were not on consecutive cycles");

	assert property (@(posedge clk) disable iff (rst)
		read_pixel_signal |-> w_shifted && b_shifted)
	else
		report_fault(3, "pixel read started before both coefficient banks were loaded");

	assert property (@(posedge clk) disable iff (rst)
		read_pixel_signal |->
			read_row_addr == p_reads / WIDTH && read_col_addr == p_reads % WIDTH)
	else
		report_mismatch(3, "{read_row_addr,read_col_addr}",
			pack_pos($sampled(p_reads) / WIDTH, $sampled(p_reads) % WIDTH),
			{$sampled(read_row_addr), $sampled(read_col_addr)});

	assert property (@(posedge clk) disable iff (rst)
		(scan_active && p_reads > 0 && p_reads < PIXELS) |-> read_pixel_signal)
	else
		report_fault(3, "pixel reads were not on consecutive cycles");

	assert property (@(posedge clk) disable iff (rst) layer_done |-> p_reads == PIXELS)
	else
		report_mismatch(3, "pixel read count", PIXELS, $sampled(p_reads));

	assert property (@(posedge clk) disable iff (rst) save_enable |-> scan_active)
	else
		report_fault(4, "save_enable seen outside a scan");

	assert property (@(posedge clk) disable iff (rst)
		save_enable |->
			output_row == save_cnt / OUT_W && output_col == save_cnt % OUT_W)
	else
		report_mismatch(4, "{output_row,output_col}",
			pack_pos($sampled(save_cnt) / OUT_W, $sampled(save_cnt) % OUT_W),
			{$sampled(output_row), $sampled(output_col)});

	for (genvar c = 0; c < CH; c++)
	begin : g_chan_check
		assert property (@(posedge clk) disable iff (rst)
			save_enable |-> output_data[c*DW +: DW] ==
				expected_channel(save_cnt / OUT_W, save_cnt % OUT_W, c))
		else
			report_mismatch(5, $sformatf("output_data[%0d]", c),
				expected_channel($sampled(save_cnt) / OUT_W, $sampled(save_cnt) % OUT_W, c),
				$sampled(output_data[c*DW +: DW]));
	end

	assert property (@(posedge clk) disable iff (rst) layer_done |-> save_enable)
	else
		report_fault(6, "layer_done pulsed without a result");

	assert property (@(posedge clk) disable iff (rst) layer_done |-> save_cnt == OUTPUTS - 1)
	else
		report_mismatch(6, "results before layer_done", OUTPUTS - 1, $sampled(save_cnt));

	initial
	begin
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_store_done = 1'b0;
		input_data = '0;
		weight_data = '0;
		bias_data = '0;
		started = 1'b0;
		lfsr = 32'hd541;
		fill_coefficients();
		fill_image();

		wait_until(GOAL_RESET_DONE, 20, "reset release");
		repeat (12) @(posedge clk);

		// pixel store done rises together with the load requests
		@(posedge clk);
		started <= 1'b1;
		weight_store_done <= 1'b1;
		bias_store_done <= 1'b1;
		pixel_store_done <= 1'b1;
		wait_until(GOAL_LOADED, 200, "coefficient banks to load");
		finish_test(1, "idle after reset");
		assert (w_reads == W_WORDS)
		else
			report_mismatch(2, "weight read count", W_WORDS, w_reads);
		assert (b_reads == CH)
		else
			report_mismatch(2, "bias read count", CH, b_reads);

		wait_until(GOAL_SCAN, 50, "first scan to start");
		pixel_store_done <= 1'b0;
		wait_until(GOAL_DONE_1, 300, "first layer_done");

		// new image for the second scan
		fill_image();
		@(posedge clk);
		pixel_store_done <= 1'b1;
		wait_until(GOAL_SCAN, 50, "second scan to start");
		pixel_store_done <= 1'b0;
		wait_until(GOAL_DONE_2, 300, "second layer_done");
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (done_cnt == 2)
		else
			report_mismatch(6, "layer_done count", 2, done_cnt);

		finish_test(2, "coefficient load addresses");
		finish_test(3, "pixel read order");
		finish_test(4, "save positions");
		finish_test(5, "output data");
		finish_test(6, "layer done and rescan");

		$display("%0d of 6 tests ok, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
verilog/conv_pkg.sv
verilog/coef_if.sv
verilog/coef_loader.sv
verilog/line_buffer.sv
verilog/pixel_window.sv
verilog/conv_mac_array.sv
verilog/scan_ctrl.sv
verilog/conv_layer_top.sv
bench/clk_rst_gen.sv
bench/conv_layer_tb.sv

// ==== include/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// image side in pixels
`define CONV_WIDTH 8

// pixel, weight, bias and result width
`define CONV_DATA_W 16

// output channels
`define CONV_CHANNELS 4

// 3x3 kernel
`define CONV_TAPS 9

// read address and row/col port width
`define CONV_ADDR_W 16

`endif

// ==== verilog/coef_if.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

interface coef_if
	import conv_pkg::*;
();

	weight_bank_t weights;
	bias_bank_t   biases;
	logic         weights_loaded;
	logic         biases_loaded;

	modport loader (output weights, output biases, output weights_loaded, output biases_loaded);

	modport mac (input weights, input biases);

	modport ctrl (input weights_loaded, input biases_loaded);

endinterface

// ==== verilog/coef_loader.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module coef_loader
	import conv_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    weight_store_done,
	input  logic                    bias_store_done,
	input  data_t                   weight_data,
	input  data_t                   bias_data,
	output logic                    read_weight_signal,
	output logic                    read_bias_signal,
	output logic [`CONV_ADDR_W-1:0] read_weight_addr,
	output logic [`CONV_ADDR_W-1:0] read_bias_addr,
	coef_if.loader                  coef
);

	localparam int W_TOTAL = `CONV_CHANNELS * `CONV_TAPS;
	localparam int B_TOTAL = `CONV_CHANNELS;

	logic                    w_run;
	logic                    w_valid;
	logic [`CONV_ADDR_W-1:0] w_rd_cnt;
	logic [`CONV_ADDR_W-1:0] w_got_cnt;
	data_t [W_TOTAL-1:0]     w_chain;

	logic                    b_run;
	logic                    b_valid;
	logic [`CONV_ADDR_W-1:0] b_rd_cnt;
	logic [`CONV_ADDR_W-1:0] b_got_cnt;
	bias_bank_t              b_chain;

	assign read_weight_signal = w_run;
	assign read_weight_addr = w_rd_cnt;
	assign read_bias_signal = b_run;
	assign read_bias_addr = b_rd_cnt;

	// weight load, one-shot after reset
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_run <= 1'b0;
			w_valid <= 1'b0;
			w_rd_cnt <= '0;
			w_got_cnt <= '0;
		end
		else
		begin
			// memory answers one cycle after the strobe
			w_valid <= w_run;
			if (w_run)
			begin
				w_rd_cnt <= w_rd_cnt + 1'b1;
				if (w_rd_cnt == W_TOTAL - 1)
					w_run <= 1'b0;
			end
			else if (weight_store_done && w_rd_cnt == '0)
				w_run <= 1'b1;
			if (w_valid)
				w_got_cnt <= w_got_cnt + 1'b1;
		end
	end

	// bias load
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			b_run <= 1'b0;
			b_valid <= 1'b0;
			b_rd_cnt <= '0;
			b_got_cnt <= '0;
		end
		else
		begin
			b_valid <= b_run;
			if (b_run)
			begin
				b_rd_cnt <= b_rd_cnt + 1'b1;
				if (b_rd_cnt == B_TOTAL - 1)
					b_run <= 1'b0;
			end
			else if (bias_store_done && b_rd_cnt == '0)
				b_run <= 1'b1;
			if (b_valid)
				b_got_cnt <= b_got_cnt + 1'b1;
		end
	end

	// newest word enters at the top, word a ends at index a
	always_ff @(posedge clk)
	begin
		if (w_valid && !coef.weights_loaded)
			w_chain <= {weight_data, w_chain[W_TOTAL-1:1]};
		if (b_valid && !coef.biases_loaded)
			b_chain <= {bias_data, b_chain[B_TOTAL-1:1]};
	end

	// address a = tap * channels + channel
	always_comb
	begin
		for (int c = 0; c < `CONV_CHANNELS; c++)
		begin
			for (int t = 0; t < `CONV_TAPS; t++)
			begin
				coef.weights[c][t] = w_chain[t*`CONV_CHANNELS+c];
			end
		end
	end

	assign coef.biases = b_chain;
	assign coef.weights_loaded = (w_got_cnt == W_TOTAL);
	assign coef.biases_loaded = (b_got_cnt == B_TOTAL);

endmodule

// ==== verilog/conv_layer_top.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_layer_top
	import conv_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   weight_store_done,
	input  logic                                   bias_store_done,
	input  logic                                   pixel_store_done,
	input  logic [`CONV_DATA_W-1:0]                input_data,
	input  logic [`CONV_DATA_W-1:0]                weight_data,
	input  logic [`CONV_DATA_W-1:0]                bias_data,
	output logic                                   save_enable,
	output logic [`CONV_ADDR_W-1:0]                output_row,
	output logic [`CONV_ADDR_W-1:0]                output_col,
	output logic [`CONV_CHANNELS*`CONV_DATA_W-1:0] output_data,
	output logic                                   layer_done,
	output logic                                   read_pixel_signal,
	output logic [`CONV_ADDR_W-1:0]                read_col_addr,
	output logic [`CONV_ADDR_W-1:0]                read_row_addr,
	output logic                                   read_weight_signal,
	output logic [`CONV_ADDR_W-1:0]                read_weight_addr,
	output logic                                   read_bias_signal,
	output logic [`CONV_ADDR_W-1:0]                read_bias_addr
);

	coef_if coef ();

	data_t [`CONV_TAPS-1:0] taps;
	conv_out_u              mac_result;

	coef_loader u_coef_loader (
		.clk                (clk),
		.rst                (rst),
		.weight_store_done  (weight_store_done),
		.bias_store_done    (bias_store_done),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.read_weight_signal (read_weight_signal),
		.read_bias_signal   (read_bias_signal),
		.read_weight_addr   (read_weight_addr),
		.read_bias_addr     (read_bias_addr),
		.coef               (coef.loader)
	);

	pixel_window u_pixel_window (
		.clk   (clk),
		.rst   (rst),
		.pixel (input_data),
		.taps  (taps)
	);

	conv_mac_array u_conv_mac_array (
		.taps   (taps),
		.coef   (coef.mac),
		.result (mac_result)
	);

	scan_ctrl u_scan_ctrl (
		.clk               (clk),
		.rst               (rst),
		.pixel_store_done  (pixel_store_done),
		.coef              (coef.ctrl),
		.read_pixel_signal (read_pixel_signal),
		.read_col_addr     (read_col_addr),
		.read_row_addr     (read_row_addr),
		.output_row        (output_row),
		.output_col        (output_col),
		.save_enable       (save_enable),
		.layer_done        (layer_done)
	);

	assign output_data = mac_result.flat;

endmodule

// ==== verilog/conv_mac_array.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_mac_array
	import conv_pkg::*;
(
	input  data_t [`CONV_TAPS-1:0] taps,
	coef_if.mac                    coef,
	output conv_out_u              result
);

	always_comb
	begin
		data_t prod [`CONV_TAPS];
		data_t lvl1 [4];
		data_t lvl2 [2];
		data_t tree_sum;

		for (int c = 0; c < `CONV_CHANNELS; c++)
		begin
			// products truncated to the data width, sums wrap
			for (int t = 0; t < `CONV_TAPS; t++)
			begin
				prod[t] = taps[t] * coef.weights[c][t];
			end
			for (int k = 0; k < 4; k++)
			begin
				lvl1[k] = prod[2*k] + prod[2*k+1];
			end
			lvl2[0] = lvl1[0] + lvl1[1];
			lvl2[1] = lvl1[2] + lvl1[3];
			// odd tap joins at the last level
			tree_sum = (lvl2[0] + lvl2[1]) + prod[8];
			result.chan[c] = tree_sum + coef.biases[c];
		end
	end

endmodule

// ==== verilog/conv_pkg.sv ====
`include "conv_params.svh"

package conv_pkg;

	typedef logic signed [`CONV_DATA_W-1:0] data_t;

	// [channel][tap], tap 3i+j is window row i, column j
	typedef data_t [`CONV_CHANNELS-1:0][`CONV_TAPS-1:0] weight_bank_t;

	typedef data_t [`CONV_CHANNELS-1:0] bias_bank_t;

	// result bus, flat for the top port or split per channel
	typedef union packed
	{
		logic [`CONV_CHANNELS*`CONV_DATA_W-1:0] flat;
		data_t [`CONV_CHANNELS-1:0]             chan;
	} conv_out_u;

	typedef enum logic [1:0]
	{
		SCAN_IDLE,
		SCAN_FILL,
		SCAN_EMIT
	} scan_state_t;

endpackage

// ==== verilog/line_buffer.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module line_buffer
	import conv_pkg::*;
#(
	parameter int DEPTH = `CONV_WIDTH - 3
)
(
	input  logic  clk,
	input  logic  rst,
	input  data_t din,
	output data_t dout
);

	data_t [DEPTH-1:0] stage;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			stage <= '0;
		else
		begin
			stage[DEPTH-1] <= din;
			for (int i = 0; i < DEPTH - 1; i++)
			begin
				stage[i] <= stage[i+1];
			end
		end
	end

	assign dout = stage[0];

endmodule

// ==== verilog/pixel_window.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module pixel_window
	import conv_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  data_t                  pixel,
	output data_t [`CONV_TAPS-1:0] taps
);

	// [row][col], row 2 and col 2 hold the newest pixels
	data_t [2:0][2:0] win;
	data_t            mid_in;
	data_t            top_in;

	// 3 window regs + (width-3) buffer stages = one image row
	line_buffer #(
		.DEPTH (`CONV_WIDTH - 3)
	) u_lb_mid (
		.clk  (clk),
		.rst  (rst),
		.din  (win[2][0]),
		.dout (mid_in)
	);

	line_buffer #(
		.DEPTH (`CONV_WIDTH - 3)
	) u_lb_top (
		.clk  (clk),
		.rst  (rst),
		.din  (win[1][0]),
		.dout (top_in)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			win <= '0;
		else
		begin
			win[2] <= {pixel, win[2][2:1]};
			win[1] <= {mid_in, win[1][2:1]};
			win[0] <= {top_in, win[0][2:1]};
		end
	end

	// packed layout puts win[i][j] at tap 3i+j
	assign taps = win;

endmodule

// ==== verilog/scan_ctrl.sv ====
`timescale 1ns/100ps
`include "conv_params.svh"

module scan_ctrl
	import conv_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    pixel_store_done,
	coef_if.ctrl                    coef,
	output logic                    read_pixel_signal,
	output logic [`CONV_ADDR_W-1:0] read_col_addr,
	output logic [`CONV_ADDR_W-1:0] read_row_addr,
	output logic [`CONV_ADDR_W-1:0] output_row,
	output logic [`CONV_ADDR_W-1:0] output_col,
	output logic                    save_enable,
	output logic                    layer_done
);

	// two rows plus two pixels to the first bottom-right corner,
	// then memory latency and the window register
	localparam int FILL_CYCLES = 2 * `CONV_WIDTH + 4;
	localparam int FILL_W = $clog2(FILL_CYCLES);
	localparam int LAST_POS = `CONV_WIDTH - 3;

	scan_state_t             state;
	logic [FILL_W-1:0]       fill_cnt;
	logic [`CONV_ADDR_W-1:0] rd_col;
	logic [`CONV_ADDR_W-1:0] rd_row;
	logic [`CONV_ADDR_W-1:0] sv_col;
	logic [`CONV_ADDR_W-1:0] sv_row;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= SCAN_IDLE;
			fill_cnt <= '0;
			rd_col <= '0;
			rd_row <= '0;
			sv_col <= '0;
			sv_row <= '0;
		end
		else
		begin
			case (state)
				SCAN_IDLE:
				begin
					fill_cnt <= '0;
					rd_col <= '0;
					rd_row <= '0;
					sv_col <= '0;
					sv_row <= '0;
					// both banks must be complete before any pixel is read
					if (pixel_store_done && coef.weights_loaded && coef.biases_loaded)
						state <= SCAN_FILL;
				end
				SCAN_FILL:
				begin
					fill_cnt <= fill_cnt + 1'b1;
					if (fill_cnt == FILL_CYCLES - 1)
						state <= SCAN_EMIT;
				end
				SCAN_EMIT:
				begin
					if (layer_done)
						state <= SCAN_IDLE;
					if (sv_col == `CONV_WIDTH - 1)
					begin
						sv_col <= '0;
						sv_row <= sv_row + 1'b1;
					end
					else
						sv_col <= sv_col + 1'b1;
				end
				default:
					state <= SCAN_IDLE;
			endcase

			// raster read order, runs through fill and emit
			if (read_pixel_signal)
			begin
				if (rd_col == `CONV_WIDTH - 1)
				begin
					rd_col <= '0;
					rd_row <= rd_row + 1'b1;
				end
				else
					rd_col <= rd_col + 1'b1;
			end
		end
	end

	assign read_pixel_signal = (state != SCAN_IDLE) && (rd_row < `CONV_WIDTH);
	assign read_col_addr = rd_col;
	assign read_row_addr = rd_row;
	assign output_row = sv_row;
	assign output_col = sv_col;

	// windows that wrap across a row edge are skipped
	assign save_enable = (state == SCAN_EMIT) && (sv_col <= LAST_POS) && (sv_row <= LAST_POS);
	assign layer_done = (state == SCAN_EMIT) && (sv_col == LAST_POS) && (sv_row == LAST_POS);

endmodule
